/* Makefile */
VERILATOR ?= verilator
TOP       ?= xbar_tb
SEED_ARGS ?= +verilator+seed+1
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(OBJ_DIR)

/* hw/axi_pkg.sv */
package axi_pkg;

	// Response codes used on R and B.
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axi_resp_e;

	localparam logic [1:0] AXI_BURST_INCR = 2'b01;

	typedef struct packed {
		logic [31:0] addr;
		logic [7:0]  len;
		logic [2:0]  size;
		logic [1:0]  burst;
	} axi_ar_t;

	typedef struct packed {
		logic [31:0] data;
		axi_resp_e   resp;
		logic        last;
	} axi_r_t;

	// Writes are single beat, so len and burst are implied.
	typedef struct packed {
		logic [31:0] addr;
		logic [2:0]  size;
	} axi_aw_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
	} axi_w_t;

	typedef struct packed {
		axi_resp_e resp;
	} axi_b_t;

endpackage

/* hw/clint.sv */
module clint (
	input  logic            clock,
	input  logic            reset,
	input  logic            ar_valid,
	input  logic [31:0]     ar_addr,
	output logic            ar_ready,
	output logic            r_valid,
	output axi_pkg::axi_r_t r,
	input  logic            r_ready
);

	import axi_pkg::*;
	import soc_map_pkg::*;

	logic [63:0] mtime;

	always_ff @(posedge clock) begin
		if (reset) begin
			mtime <= '0;
		end else begin
			mtime <= mtime + 64'd1;
		end
	end

	// One response slot.
	assign ar_ready = !r_valid;

	always_ff @(posedge clock) begin
		if (reset) begin
			r_valid <= 1'b0;
		end else if (ar_valid && ar_ready) begin
			r_valid <= 1'b1;
		end else if (r_ready) begin
			r_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (ar_valid && ar_ready) begin
			case (ar_addr[15:0])
				MTIME_LO_OFS: r <= '{data: mtime[31:0], resp: OKAY, last: 1'b1};
				MTIME_HI_OFS: r <= '{data: mtime[63:32], resp: OKAY, last: 1'b1};
				default:      r <= '{data: 32'd0, resp: SLVERR, last: 1'b1};
			endcase
		end
	end

endmodule

/* hw/soc_map_pkg.sv */
package soc_map_pkg;

	localparam logic [31:0] CLINT_BASE_DEFAULT = 32'h0200_0000;
	localparam logic [31:0] CLINT_SIZE_DEFAULT = 32'h0001_0000;

	// mtime word offsets inside the CLINT window.
	localparam logic [15:0] MTIME_LO_OFS = 16'hBFF8;
	localparam logic [15:0] MTIME_HI_OFS = 16'hBFFC;

	typedef enum logic {TGT_SOC, TGT_CLINT} read_target_e;

	typedef enum logic [1:0] {
		GNT_IDLE = 2'd0,
		GNT_IFU  = 2'd1,
		GNT_LSU  = 2'd2
	} grant_state_e;

endpackage

/* hw/xbar_arbiter.sv */
module xbar_arbiter (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      ifu_ar_valid,
	input  logic                      lsu_ar_valid,
	input  logic                      read_done,
	output soc_map_pkg::grant_state_e grant
);

	import soc_map_pkg::*;

	grant_state_e state;
	grant_state_e state_next;

	// Fixed priority, IFU first.
	always_comb begin
		state_next = state;
		case (state)
			GNT_IDLE: begin
				if (ifu_ar_valid) begin
					state_next = GNT_IFU;
				end else if (lsu_ar_valid) begin
					state_next = GNT_LSU;
				end
			end
			GNT_IFU, GNT_LSU: begin
				// Owner keeps the path through the whole burst.
				if (read_done) begin
					state_next = GNT_IDLE;
				end
			end
			default: begin
				state_next = GNT_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= GNT_IDLE;
		end else begin
			state <= state_next;
		end
	end

	assign grant = state;

endmodule

/* hw/xbar_read_route.sv */
module xbar_read_route #(
	parameter logic [31:0] CLINT_BASE = soc_map_pkg::CLINT_BASE_DEFAULT,
	parameter logic [31:0] CLINT_SIZE = soc_map_pkg::CLINT_SIZE_DEFAULT
) (
	input  soc_map_pkg::grant_state_e grant,

	input  logic             ifu_ar_valid,
	input  axi_pkg::axi_ar_t ifu_ar,
	output logic             ifu_ar_ready,
	output logic             ifu_r_valid,
	output axi_pkg::axi_r_t  ifu_r,
	input  logic             ifu_r_ready,

	input  logic             lsu_ar_valid,
	input  axi_pkg::axi_ar_t lsu_ar,
	output logic             lsu_ar_ready,
	output logic             lsu_r_valid,
	output axi_pkg::axi_r_t  lsu_r,
	input  logic             lsu_r_ready,

	output logic             io_ar_valid,
	output axi_pkg::axi_ar_t io_ar,
	input  logic             io_ar_ready,
	input  logic             io_r_valid,
	input  axi_pkg::axi_r_t  io_r,
	output logic             io_r_ready,

	output logic             clint_ar_valid,
	output logic [31:0]      clint_ar_addr,
	input  logic             clint_ar_ready,
	input  logic             clint_r_valid,
	input  axi_pkg::axi_r_t  clint_r,
	output logic             clint_r_ready,

	output logic             read_done
);

	import axi_pkg::*;
	import soc_map_pkg::*;

	logic [31:0]  lsu_ofs;
	read_target_e lsu_target;
	read_target_e target;
	logic         sel_ar_valid;
	axi_ar_t      sel_ar;
	logic         sel_ar_ready;
	logic         sel_r_ready;
	logic         tgt_r_valid;
	axi_r_t       tgt_r;

	// Offset compare avoids overflow of base plus size.
	assign lsu_ofs    = lsu_ar.addr - CLINT_BASE;
	assign lsu_target = (lsu_ar.addr >= CLINT_BASE && lsu_ofs < CLINT_SIZE) ? TGT_CLINT : TGT_SOC;
	assign target     = (grant == GNT_LSU) ? lsu_target : TGT_SOC;

	always_comb begin
		sel_ar_valid = 1'b0;
		sel_ar       = '0;
		sel_r_ready  = 1'b0;
		case (grant)
			GNT_IFU: begin
				sel_ar_valid = ifu_ar_valid;
				sel_ar       = ifu_ar;
				sel_r_ready  = ifu_r_ready;
			end
			GNT_LSU: begin
				// LSU reads are always single beat.
				sel_ar_valid = lsu_ar_valid;
				sel_ar       = lsu_ar;
				sel_ar.len   = '0;
				sel_ar.burst = AXI_BURST_INCR;
				sel_r_ready  = lsu_r_ready;
			end
			default: begin
				sel_r_ready = 1'b0;
			end
		endcase
	end

	assign io_ar_valid    = sel_ar_valid && (target == TGT_SOC);
	assign io_ar          = sel_ar;
	assign clint_ar_valid = sel_ar_valid && (target == TGT_CLINT);
	assign clint_ar_addr  = sel_ar.addr;
	assign sel_ar_ready   = (target == TGT_CLINT) ? clint_ar_ready : io_ar_ready;

	assign io_r_ready    = sel_r_ready && (target == TGT_SOC);
	assign clint_r_ready = sel_r_ready && (target == TGT_CLINT);

	always_comb begin
		if (target == TGT_CLINT) begin
			tgt_r_valid = clint_r_valid;
			tgt_r       = clint_r;
			tgt_r.last  = 1'b1;
		end else begin
			tgt_r_valid = io_r_valid;
			tgt_r       = io_r;
		end
	end

	assign ifu_ar_ready = (grant == GNT_IFU) && sel_ar_ready;
	assign lsu_ar_ready = (grant == GNT_LSU) && sel_ar_ready;
	assign ifu_r_valid  = (grant == GNT_IFU) && tgt_r_valid;
	assign lsu_r_valid  = (grant == GNT_LSU) && tgt_r_valid;
	assign ifu_r        = tgt_r;
	assign lsu_r        = tgt_r;

	// sel_r_ready is low while idle, so stray beats never end a read.
	assign read_done = tgt_r_valid && sel_r_ready && tgt_r.last;

endmodule

/* hw/xbar_top.sv */
module xbar_top #(
	parameter logic [31:0] CLINT_BASE = soc_map_pkg::CLINT_BASE_DEFAULT,
	parameter logic [31:0] CLINT_SIZE = soc_map_pkg::CLINT_SIZE_DEFAULT
) (
	input  logic             clock,
	input  logic             reset,

	input  logic             ifu_ar_valid,
	input  axi_pkg::axi_ar_t ifu_ar,
	output logic             ifu_ar_ready,
	output logic             ifu_r_valid,
	output axi_pkg::axi_r_t  ifu_r,
	input  logic             ifu_r_ready,

	input  logic             lsu_ar_valid,
	input  axi_pkg::axi_ar_t lsu_ar,
	output logic             lsu_ar_ready,
	output logic             lsu_r_valid,
	output axi_pkg::axi_r_t  lsu_r,
	input  logic             lsu_r_ready,
	input  logic             lsu_aw_valid,
	input  axi_pkg::axi_aw_t lsu_aw,
	output logic             lsu_aw_ready,
	input  logic             lsu_w_valid,
	input  axi_pkg::axi_w_t  lsu_w,
	output logic             lsu_w_ready,
	output logic             lsu_b_valid,
	output axi_pkg::axi_b_t  lsu_b,
	input  logic             lsu_b_ready,

	output logic             io_ar_valid,
	output axi_pkg::axi_ar_t io_ar,
	input  logic             io_ar_ready,
	input  logic             io_r_valid,
	input  axi_pkg::axi_r_t  io_r,
	output logic             io_r_ready,
	output logic             io_aw_valid,
	output axi_pkg::axi_aw_t io_aw,
	input  logic             io_aw_ready,
	output logic             io_w_valid,
	output axi_pkg::axi_w_t  io_w,
	output logic             io_w_last,
	input  logic             io_w_ready,
	input  logic             io_b_valid,
	input  axi_pkg::axi_b_t  io_b,
	output logic             io_b_ready
);

	import axi_pkg::*;
	import soc_map_pkg::*;

	grant_state_e grant;
	logic         read_done;
	logic         clint_ar_valid;
	logic [31:0]  clint_ar_addr;
	logic         clint_ar_ready;
	logic         clint_r_valid;
	axi_r_t       clint_r;
	logic         clint_r_ready;

	xbar_arbiter i_arbiter (
		.clock        (clock),
		.reset        (reset),
		.ifu_ar_valid (ifu_ar_valid),
		.lsu_ar_valid (lsu_ar_valid),
		.read_done    (read_done),
		.grant        (grant)
	);

	xbar_read_route #(
		.CLINT_BASE (CLINT_BASE),
		.CLINT_SIZE (CLINT_SIZE)
	) i_read_route (
		.grant          (grant),
		.ifu_ar_valid   (ifu_ar_valid),
		.ifu_ar         (ifu_ar),
		.ifu_ar_ready   (ifu_ar_ready),
		.ifu_r_valid    (ifu_r_valid),
		.ifu_r          (ifu_r),
		.ifu_r_ready    (ifu_r_ready),
		.lsu_ar_valid   (lsu_ar_valid),
		.lsu_ar         (lsu_ar),
		.lsu_ar_ready   (lsu_ar_ready),
		.lsu_r_valid    (lsu_r_valid),
		.lsu_r          (lsu_r),
		.lsu_r_ready    (lsu_r_ready),
		.io_ar_valid    (io_ar_valid),
		.io_ar          (io_ar),
		.io_ar_ready    (io_ar_ready),
		.io_r_valid     (io_r_valid),
		.io_r           (io_r),
		.io_r_ready     (io_r_ready),
		.clint_ar_valid (clint_ar_valid),
		.clint_ar_addr  (clint_ar_addr),
		.clint_ar_ready (clint_ar_ready),
		.clint_r_valid  (clint_r_valid),
		.clint_r        (clint_r),
		.clint_r_ready  (clint_r_ready),
		.read_done      (read_done)
	);

	// Writes bypass the read arbiter entirely.
	xbar_write_path i_write_path (
		.clock        (clock),
		.reset        (reset),
		.lsu_aw_valid (lsu_aw_valid),
		.lsu_aw       (lsu_aw),
		.lsu_aw_ready (lsu_aw_ready),
		.lsu_w_valid  (lsu_w_valid),
		.lsu_w        (lsu_w),
		.lsu_w_ready  (lsu_w_ready),
		.lsu_b_valid  (lsu_b_valid),
		.lsu_b        (lsu_b),
		.lsu_b_ready  (lsu_b_ready),
		.io_aw_valid  (io_aw_valid),
		.io_aw        (io_aw),
		.io_aw_ready  (io_aw_ready),
		.io_w_valid   (io_w_valid),
		.io_w         (io_w),
		.io_w_last    (io_w_last),
		.io_w_ready   (io_w_ready),
		.io_b_valid   (io_b_valid),
		.io_b         (io_b),
		.io_b_ready   (io_b_ready)
	);

	clint i_clint (
		.clock    (clock),
		.reset    (reset),
		.ar_valid (clint_ar_valid),
		.ar_addr  (clint_ar_addr),
		.ar_ready (clint_ar_ready),
		.r_valid  (clint_r_valid),
		.r        (clint_r),
		.r_ready  (clint_r_ready)
	);

endmodule

/* hw/xbar_write_path.sv */
module xbar_write_path (
	input  logic             clock,
	input  logic             reset,

	input  logic             lsu_aw_valid,
	input  axi_pkg::axi_aw_t lsu_aw,
	output logic             lsu_aw_ready,
	input  logic             lsu_w_valid,
	input  axi_pkg::axi_w_t  lsu_w,
	output logic             lsu_w_ready,
	output logic             lsu_b_valid,
	output axi_pkg::axi_b_t  lsu_b,
	input  logic             lsu_b_ready,

	output logic             io_aw_valid,
	output axi_pkg::axi_aw_t io_aw,
	input  logic             io_aw_ready,
	output logic             io_w_valid,
	output axi_pkg::axi_w_t  io_w,
	output logic             io_w_last,
	input  logic             io_w_ready,
	input  logic             io_b_valid,
	input  axi_pkg::axi_b_t  io_b,
	output logic             io_b_ready
);

	logic aw_sent;
	logic w_sent;

	// A sent channel stays closed until its B arrives.
	assign io_aw_valid  = lsu_aw_valid && !aw_sent;
	assign lsu_aw_ready = io_aw_ready && !aw_sent;
	assign io_aw        = lsu_aw;

	assign io_w_valid  = lsu_w_valid && !w_sent;
	assign lsu_w_ready = io_w_ready && !w_sent;
	assign io_w        = lsu_w;
	assign io_w_last   = 1'b1;

	assign lsu_b_valid = io_b_valid;
	assign lsu_b       = io_b;
	assign io_b_ready  = lsu_b_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			aw_sent <= 1'b0;
			w_sent  <= 1'b0;
		end else if (io_b_valid && lsu_b_ready) begin
			aw_sent <= 1'b0;
			w_sent  <= 1'b0;
		end else begin
			if (io_aw_valid && io_aw_ready) begin
				aw_sent <= 1'b1;
			end
			if (io_w_valid && io_w_ready) begin
				w_sent <= 1'b1;
			end
		end
	end

endmodule

/* testbench/axi_mem_model.sv */
module axi_mem_model #(
	parameter int MEM_WORDS = 1024
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             ar_valid,
	input  axi_pkg::axi_ar_t ar,
	output logic             ar_ready,
	output logic             r_valid,
	output axi_pkg::axi_r_t  r,
	input  logic             r_ready,
	input  logic             aw_valid,
	input  axi_pkg::axi_aw_t aw,
	output logic             aw_ready,
	input  logic             w_valid,
	input  axi_pkg::axi_w_t  w,
	input  logic             w_last,
	output logic             w_ready,
	output logic             b_valid,
	output axi_pkg::axi_b_t  b,
	input  logic             b_ready
);

	timeunit 1ns;
	timeprecision 100ps;

	import axi_pkg::*;

	localparam int IDX_W = $clog2(MEM_WORDS);

	logic [31:0] mem [MEM_WORDS];
	logic        rd_busy;
	logic [31:0] rd_addr;
	logic [7:0]  rd_left;
	logic        aw_have;
	logic        w_have;
	logic [31:0] wr_addr;
	logic [31:0] wr_data;
	logic [3:0]  wr_strb;
	logic        wr_last;
	logic        ready_phase;

	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = (32'(i) << 2) ^ 32'hA5A5_0000;
		end
	end

	// AR and AW are only accepted on every other cycle.
	always_ff @(posedge clock) begin
		if (reset) begin
			ready_phase <= 1'b0;
		end else begin
			ready_phase <= !ready_phase;
		end
	end

	assign ar_ready = !rd_busy && ready_phase;
	assign r_valid  = rd_busy;
	assign r        = '{data: mem[rd_addr[IDX_W+1:2]], resp: OKAY, last: (rd_left == 8'd0)};

	// Incrementing burst, one beat per accepted R.
	always_ff @(posedge clock) begin
		if (reset) begin
			rd_busy <= 1'b0;
		end else if (ar_valid && ar_ready) begin
			rd_busy <= 1'b1;
			rd_addr <= ar.addr;
			rd_left <= ar.len;
		end else if (r_valid && r_ready) begin
			if (rd_left == 8'd0) begin
				rd_busy <= 1'b0;
			end else begin
				rd_addr <= rd_addr + 32'd4;
				rd_left <= rd_left - 8'd1;
			end
		end
	end

	assign aw_ready = !aw_have && !b_valid && ready_phase;
	assign w_ready  = !w_have && !b_valid;

	// A single-beat write without last is answered with SLVERR.
	always_comb begin
		b.resp = wr_last ? OKAY : SLVERR;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			aw_have <= 1'b0;
			w_have  <= 1'b0;
			b_valid <= 1'b0;
		end else begin
			if (aw_valid && aw_ready) begin
				aw_have <= 1'b1;
				wr_addr <= aw.addr;
			end
			if (w_valid && w_ready) begin
				w_have  <= 1'b1;
				wr_data <= w.data;
				wr_strb <= w.strb;
				wr_last <= w_last;
			end
			if (aw_have && w_have) begin
				aw_have <= 1'b0;
				w_have  <= 1'b0;
				b_valid <= 1'b1;
			end else if (b_valid && b_ready) begin
				b_valid <= 1'b0;
			end
		end
	end

	always @(posedge clock) begin
		if (!reset && aw_have && w_have) begin
			for (int i = 0; i < 4; i++) begin
				if (wr_strb[i]) begin
					mem[wr_addr[IDX_W+1:2]][8*i +: 8] <= wr_data[8*i +: 8];
				end
			end
		end
	end

endmodule

/* testbench/xbar_chk.sv */
module xbar_chk (
	input logic                      clock,
	input logic                      reset,
	input logic                      lsu_ar_valid,
	input logic                      lsu_ar_ready,
	input axi_pkg::axi_ar_t          lsu_ar,
	input logic                      io_ar_valid,
	input logic                      io_ar_ready,
	input axi_pkg::axi_ar_t          io_ar,
	input logic                      io_r_valid,
	input logic                      io_r_ready,
	input axi_pkg::axi_r_t           io_r,
	input logic                      io_aw_valid,
	input logic                      io_aw_ready,
	input axi_pkg::axi_aw_t          io_aw,
	input logic                      clint_ar_valid,
	input logic                      clint_r_valid,
	input soc_map_pkg::grant_state_e grant
);

	timeunit 1ns;
	timeprecision 100ps;

	import soc_map_pkg::*;

	a_lsu_ar_stable: assert property (@(posedge clock) disable iff (reset)
		lsu_ar_valid && !lsu_ar_ready |=> lsu_ar_valid && $stable(lsu_ar))
		else $error("lsu_ar dropped or changed before ready");

	a_io_ar_stable: assert property (@(posedge clock) disable iff (reset)
		io_ar_valid && !io_ar_ready |=> io_ar_valid && $stable(io_ar))
		else $error("io_ar dropped or changed before ready");

	a_io_r_stable: assert property (@(posedge clock) disable iff (reset)
		io_r_valid && !io_r_ready |=> io_r_valid && $stable(io_r))
		else $error("io_r dropped or changed before ready");

	a_io_aw_stable: assert property (@(posedge clock) disable iff (reset)
		io_aw_valid && !io_aw_ready |=> io_aw_valid && $stable(io_aw))
		else $error("io_aw dropped or changed before ready");

	// Only one read target at a time.
	a_ar_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(io_ar_valid && clint_ar_valid))
		else $error("io_ar and clint_ar valid together");

	a_clint_owner: assert property (@(posedge clock) disable iff (reset)
		clint_r_valid |-> grant == GNT_LSU)
		else $error("CLINT response without LSU grant");

endmodule

bind xbar_top xbar_chk i_chk (
	.clock          (clock),
	.reset          (reset),
	.lsu_ar_valid   (lsu_ar_valid),
	.lsu_ar_ready   (lsu_ar_ready),
	.lsu_ar         (lsu_ar),
	.io_ar_valid    (io_ar_valid),
	.io_ar_ready    (io_ar_ready),
	.io_ar          (io_ar),
	.io_r_valid     (io_r_valid),
	.io_r_ready     (io_r_ready),
	.io_r           (io_r),
	.io_aw_valid    (io_aw_valid),
	.io_aw_ready    (io_aw_ready),
	.io_aw          (io_aw),
	.clint_ar_valid (clint_ar_valid),
	.clint_r_valid  (clint_r_valid),
	.grant          (grant)
);

/* testbench/xbar_tb.sv */
module xbar_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import axi_pkg::*;
	import soc_map_pkg::*;

	typedef enum int {OP_RD, OP_WR, OP_TIME, OP_DUAL} op_e;

	typedef struct {
		op_e         op;
		bit          is_ifu;
		logic [31:0] addr;
		logic [7:0]  len;
		logic [31:0] addr2;
		logic [31:0] wdata;
		logic [3:0]  strb;
		logic [31:0] exp_data;
		axi_resp_e   exp_resp;
	} entry_t;

	localparam int N_ENTRIES   = 11;
	localparam int RESET_CYCLES = 10;
	localparam int CYCLE_LIMIT = 64 * N_ENTRIES + RESET_CYCLES;

	logic    clock = 1'b0;
	logic    reset;
	logic    ifu_ar_valid, ifu_ar_ready, ifu_r_valid, ifu_r_ready;
	axi_ar_t ifu_ar;
	axi_r_t  ifu_r;
	logic    lsu_ar_valid, lsu_ar_ready, lsu_r_valid, lsu_r_ready;
	axi_ar_t lsu_ar;
	axi_r_t  lsu_r;
	logic    lsu_aw_valid, lsu_aw_ready, lsu_w_valid, lsu_w_ready, lsu_b_valid, lsu_b_ready;
	axi_aw_t lsu_aw;
	axi_w_t  lsu_w;
	axi_b_t  lsu_b;
	logic    io_ar_valid, io_ar_ready, io_r_valid, io_r_ready;
	axi_ar_t io_ar;
	axi_r_t  io_r;
	logic    io_aw_valid, io_aw_ready, io_w_valid, io_w_last, io_w_ready;
	logic    io_b_valid, io_b_ready;
	axi_aw_t io_aw;
	axi_w_t  io_w;
	axi_b_t  io_b;

	entry_t      table_q [N_ENTRIES];
	axi_r_t      beats [2][16];
	int          beat_n [2];
	int          last_cycle [2];
	int          cycles = 0;
	int          io_ar_count = 0;
	int          seed = 32'h1d6e_920b;
	logic [31:0] prev_time;
	bit          have_time;

	xbar_top #(
		.CLINT_BASE (CLINT_BASE_DEFAULT),
		.CLINT_SIZE (CLINT_SIZE_DEFAULT)
	) i_dut (.*);

	axi_mem_model #(.MEM_WORDS(1024)) i_mem (
		.clock (clock), .reset (reset),
		.ar_valid (io_ar_valid), .ar (io_ar), .ar_ready (io_ar_ready),
		.r_valid (io_r_valid), .r (io_r), .r_ready (io_r_ready),
		.aw_valid (io_aw_valid), .aw (io_aw), .aw_ready (io_aw_ready),
		.w_valid (io_w_valid), .w (io_w), .w_last (io_w_last), .w_ready (io_w_ready),
		.b_valid (io_b_valid), .b (io_b), .b_ready (io_b_ready)
	);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (io_ar_valid && io_ar_ready) begin
			io_ar_count <= io_ar_count + 1;
		end
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout: no response after %0d cycles", cycles);
			$display("TEST RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	function automatic logic [31:0] init_word(input logic [31:0] addr);
		return addr ^ 32'hA5A5_0000;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
			input logic [31:0] new_word, input logic [3:0] strb);
		logic [31:0] res;
		res = old_word;
		for (int i = 0; i < 4; i++) begin
			if (strb[i]) begin
				res[8*i +: 8] = new_word[8*i +: 8];
			end
		end
		return res;
	endfunction

	task automatic report_fail(input string msg);
		$display("Fail %0t: %s", $time, msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "check failed");
	endtask

	task automatic check_r(input axi_r_t got, input axi_r_t exp, input bit with_data,
			input string what);
		if (got.resp != exp.resp || got.last != exp.last
				|| (with_data && got.data != exp.data)) begin
			report_fail($sformatf("%s R got %h/%s/%b expected %h/%s/%b", what, got.data,
				got.resp.name(), got.last, exp.data, exp.resp.name(), exp.last));
		end
	endtask

	task automatic check_b(input axi_b_t got, input axi_b_t exp, input string what);
		if (got.resp != exp.resp) begin
			report_fail($sformatf("%s B got %s expected %s", what, got.resp.name(),
				exp.resp.name()));
		end
	endtask

	task automatic set_entry(input int idx, input op_e op, input bit is_ifu,
			input logic [31:0] addr, input logic [7:0] len, input logic [31:0] addr2,
			input logic [31:0] wdata, input logic [3:0] strb, input logic [31:0] exp_data,
			input axi_resp_e exp_resp);
		table_q[idx] = '{op, is_ifu, addr, len, addr2, wdata, strb, exp_data, exp_resp};
	endtask

	task automatic build_table();
		logic [31:0] wd_a;
		logic [31:0] wd_b;
		int          first;
		wd_a = $random(seed);
		wd_b = $random(seed);
		// Write group order is picked from the seed.
		first = ($random(seed) & 1) ? 4 : 2;
		set_entry(0, OP_RD, 1, 32'h100, 8'd3, 0, 0, 0, init_word(32'h100), OKAY);
		set_entry(1, OP_RD, 0, 32'h204, 8'd0, 0, 0, 0, init_word(32'h204), OKAY);
		set_entry(first, OP_WR, 0, 32'h300, 8'd0, 0, wd_a, 4'b0101, 0, OKAY);
		set_entry(first + 1, OP_RD, 0, 32'h300, 8'd0, 0, 0, 0,
			merge_bytes(init_word(32'h300), wd_a, 4'b0101), OKAY);
		set_entry(6 - first, OP_WR, 0, 32'h310, 8'd0, 0, wd_b, 4'b1100, 0, OKAY);
		set_entry(7 - first, OP_RD, 0, 32'h310, 8'd0, 0, 0, 0,
			merge_bytes(init_word(32'h310), wd_b, 4'b1100), OKAY);
		set_entry(6, OP_TIME, 0, CLINT_BASE_DEFAULT + MTIME_LO_OFS, 8'd0, 0, 0, 0, 0, OKAY);
		set_entry(7, OP_TIME, 0, CLINT_BASE_DEFAULT + MTIME_LO_OFS, 8'd0, 0, 0, 0, 0, OKAY);
		set_entry(8, OP_RD, 0, CLINT_BASE_DEFAULT + MTIME_HI_OFS, 8'd0, 0, 0, 0, 0, OKAY);
		set_entry(9, OP_RD, 0, CLINT_BASE_DEFAULT + 32'h10, 8'd0, 0, 0, 0, 0, SLVERR);
		set_entry(10, OP_DUAL, 1, 32'h400, 8'd1, 32'h500, 0, 0, init_word(32'h400), OKAY);
	endtask

	// Issues one AR and collects R beats until last, sampling at the falling edge.
	task automatic read_txn(input bit is_ifu, input logic [31:0] addr, input logic [7:0] len);
		axi_ar_t ar;
		logic    rdy;
		logic    rv;
		logic    rr;
		axi_r_t  rb;
		bit      done;
		bit      stall;
		int      m;
		ar = '{addr: addr, len: len, size: 3'd2, burst: AXI_BURST_INCR};
		m = is_ifu ? 1 : 0;
		beat_n[m] = 0;
		done = 1'b0;
		@(posedge clock);
		if (is_ifu) begin
			ifu_ar_valid <= 1'b1;
			ifu_ar       <= ar;
		end else begin
			lsu_ar_valid <= 1'b1;
			lsu_ar       <= ar;
		end
		do begin
			@(negedge clock);
			rdy = is_ifu ? ifu_ar_ready : lsu_ar_ready;
			@(posedge clock);
		end while (!rdy);
		if (is_ifu) begin
			ifu_ar_valid <= 1'b0;
		end else begin
			lsu_ar_valid <= 1'b0;
		end
		while (!done) begin
			@(negedge clock);
			rv = is_ifu ? ifu_r_valid : lsu_r_valid;
			rr = is_ifu ? ifu_r_ready : lsu_r_ready;
			rb = is_ifu ? ifu_r : lsu_r;
			if (rv && rr) begin
				if (beat_n[m] < 16) begin
					beats[m][beat_n[m]] = rb;
				end
				beat_n[m]++;
				last_cycle[m] = cycles;
				done = rb.last;
			end
			@(posedge clock);
			// Random R back-pressure.
			stall = ($random(seed) & 3) == 0;
			if (is_ifu) begin
				ifu_r_ready <= !stall;
			end else begin
				lsu_r_ready <= !stall;
			end
		end
	endtask

	task automatic write_txn(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output axi_b_t b);
		bit aw_done;
		bit w_done;
		bit aw_hs;
		bit w_hs;
		bit got;
		aw_done = 1'b0;
		w_done = 1'b0;
		got = 1'b0;
		@(posedge clock);
		lsu_aw_valid <= 1'b1;
		lsu_aw       <= '{addr: addr, size: 3'd2};
		lsu_w_valid  <= 1'b1;
		lsu_w        <= '{data: data, strb: strb};
		while (!(aw_done && w_done)) begin
			@(negedge clock);
			aw_hs = lsu_aw_valid && lsu_aw_ready;
			w_hs = lsu_w_valid && lsu_w_ready;
			@(posedge clock);
			if (aw_hs) begin
				lsu_aw_valid <= 1'b0;
				aw_done = 1'b1;
			end
			if (w_hs) begin
				lsu_w_valid <= 1'b0;
				w_done = 1'b1;
			end
		end
		while (!got) begin
			@(negedge clock);
			if (lsu_b_valid) begin
				b = lsu_b;
				got = 1'b1;
			end
			@(posedge clock);
		end
	endtask

	// Beat zero expects exp_data, later beats follow the fill rule.
	task automatic check_read(input int m, input logic [31:0] addr, input logic [7:0] len,
			input logic [31:0] exp_data, input axi_resp_e resp, input string what);
		axi_r_t exp;
		if (beat_n[m] != int'(len) + 1) begin
			report_fail($sformatf("%s got %0d beats expected %0d", what, beat_n[m],
				int'(len) + 1));
		end
		for (int i = 0; i <= int'(len); i++) begin
			exp.data = (i == 0) ? exp_data : init_word(addr + 32'(4 * i));
			exp.resp = resp;
			exp.last = (i == int'(len));
			check_r(beats[m][i], exp, 1'b1, $sformatf("%s beat %0d", what, i));
		end
	endtask

	task automatic apply_entry(input int idx);
		entry_t e;
		axi_b_t b;
		axi_b_t exp_b;
		axi_r_t exp;
		int     io_before;
		string  what;
		e = table_q[idx];
		what = $sformatf("entry %0d", idx);
		io_before = io_ar_count;
		case (e.op)
			OP_RD: begin
				read_txn(e.is_ifu, e.addr, e.len);
				check_read(e.is_ifu ? 1 : 0, e.addr, e.len, e.exp_data, e.exp_resp, what);
				if (!e.is_ifu && e.addr >= CLINT_BASE_DEFAULT && io_ar_count != io_before) begin
					report_fail($sformatf("%s CLINT read reached the SoC port", what));
				end
			end
			OP_WR: begin
				write_txn(e.addr, e.wdata, e.strb, b);
				exp_b.resp = e.exp_resp;
				check_b(b, exp_b, what);
			end
			OP_TIME: begin
				read_txn(1'b0, e.addr, 8'd0);
				exp = '{data: 32'd0, resp: OKAY, last: 1'b1};
				check_r(beats[0][0], exp, 1'b0, what);
				if (have_time && beats[0][0].data <= prev_time) begin
					report_fail($sformatf("%s mtime %0d not above %0d", what,
						beats[0][0].data, prev_time));
				end
				prev_time = beats[0][0].data;
				have_time = 1'b1;
			end
			default: begin
				// The LSU asks for a burst here and must still get a single beat.
				fork
					read_txn(1'b1, e.addr, e.len);
					read_txn(1'b0, e.addr2, 8'd3);
				join
				check_read(1, e.addr, e.len, e.exp_data, OKAY, {what, " IFU"});
				check_read(0, e.addr2, 8'd0, init_word(e.addr2), OKAY, {what, " LSU"});
				if (last_cycle[1] >= last_cycle[0]) begin
					report_fail($sformatf("%s LSU data arrived before IFU finished", what));
				end
			end
		endcase
	endtask

	initial begin
		reset = 1'b1;
		ifu_ar_valid = 1'b0;
		ifu_ar = '0;
		ifu_r_ready = 1'b1;
		lsu_ar_valid = 1'b0;
		lsu_ar = '0;
		lsu_r_ready = 1'b1;
		lsu_aw_valid = 1'b0;
		lsu_aw = '0;
		lsu_w_valid = 1'b0;
		lsu_w = '0;
		lsu_b_ready = 1'b1;
		have_time = 1'b0;
		prev_time = '0;
		build_table();
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		for (int i = 0; i < N_ENTRIES; i++) begin
			apply_entry(i);
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* verilog.f */
hw/axi_pkg.sv
hw/soc_map_pkg.sv
hw/xbar_arbiter.sv
hw/xbar_read_route.sv
hw/xbar_write_path.sv
hw/clint.sv
hw/xbar_top.sv
testbench/axi_mem_model.sv
testbench/xbar_chk.sv
testbench/xbar_tb.sv
